// File: hdl/cpu_test_pkg.sv
/*
 * memory test sequencer definitions
 * microcode encodings, bus widths, program labels and the test pattern
 */
package cpu_test_pkg;

   localparam int BUS_ADDR_W = 22;
   localparam int BUS_DATA_W = 32;
   localparam int UPC_W      = 8;
   localparam int UTARGET_W  = 6;

   typedef logic [UPC_W-1:0]      upc_t;
   typedef logic [UTARGET_W-1:0]  utarget_t;
   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [BUS_DATA_W-1:0] bus_data_t;

   typedef enum logic [3:0] {
      op_nop   = 4'd0,
      op_write = 4'd1,
      op_read  = 4'd2,
      op_add   = 4'd3,
      op_sub   = 4'd4,
      op_tst   = 4'd5,
      op_cmp   = 4'd6,
      op_jmp   = 4'd7,
      op_fault = 4'd15
   } op_t;

   typedef enum logic [2:0] {
      r_none = 3'd0,
      r_a    = 3'd1,   // address
      r_b    = 3'd2,   // count
      r_c    = 3'd3,   // scratch
      r_d    = 3'd4,   // data
      r_i    = 3'd5,   // immediate
      r_dd   = 3'd7    // expected pattern at a
   } reg_sel_t;

   // 48 bit microword with op in the top nibble
   typedef struct packed {
      op_t       op;
      reg_sel_t  dst;
      reg_sel_t  src;
      utarget_t  target;
      bus_data_t imm;
   } uword_t;

   localparam int FILL_COUNT = 32;

   // program labels
   localparam upc_t PC_START       = 8'h00;
   localparam upc_t PC_FILL_LOOP   = 8'h02;
   localparam upc_t PC_VERIFY      = 8'h08;
   localparam upc_t PC_VERIFY_LOOP = 8'h0a;
   localparam upc_t PC_VERIFY_NEXT = 8'h0d;
   localparam upc_t HALT_PC        = 8'h11;

   // data word expected at a bus address, built from its low byte
   function automatic bus_data_t pattern_word(bus_addr_t addr);
      logic [7:0] n;
      n = addr[7:0];
      return {~n, n, n ^ 8'h5a, n + 8'h33};
   endfunction

endpackage

// File: hdl/cpu_test_req_if.sv
/*
 * request channel from the sequencer to the bus master
 * req is a level, ack and done are single cycle answers
 */
`timescale 1ns/100ps

interface cpu_test_req_if
   import cpu_test_pkg::*;
   ();

   logic      req;     // held for the whole microinstruction
   logic      wr;
   bus_addr_t addr;
   bus_data_t wdata;
   logic      ack;     // write finished
   logic      done;    // read finished, rdata valid
   bus_data_t rdata;

   modport cpu (
      output req,
      output wr,
      output addr,
      output wdata,
      input  ack,
      input  done,
      input  rdata
   );

   modport master (
      input  req,
      input  wr,
      input  addr,
      input  wdata,
      output ack,
      output done,
      output rdata
   );

endinterface

// File: hdl/cpu_test_ucode_rom.sv
/*
 * microcode ROM of the memory test sequencer
 * fills the test window, reads it back against the pattern, then halts
 */
`timescale 1ns/100ps

module cpu_test_ucode_rom
   import cpu_test_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  upc_t   uaddr,
   output uword_t uword
);

   function automatic uword_t uw(
      op_t       op,
      reg_sel_t  dst,
      reg_sel_t  src,
      upc_t      target,
      bus_data_t imm
   );
      uword_t w;
      w.op     = op;
      w.dst    = dst;
      w.src    = src;
      w.target = target[UTARGET_W-1:0];
      w.imm    = imm;
      return w;
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
         uword <= uw(op_nop, r_none, r_none, PC_START, '0);
      else
      begin
         case (uaddr)
            // fill
            8'h00:
               uword <= uw(op_add, r_a, r_none, PC_START, 32'd0);    // a = 0
            8'h01:
               uword <= uw(op_add, r_b, r_none, PC_START, 32'd0);    // b = 0
            PC_FILL_LOOP:
               uword <= uw(op_add, r_d, r_dd, PC_START, 32'd0);      // d = pattern
            8'h03:
               uword <= uw(op_write, r_none, r_none, PC_START, 32'd0);
            8'h04:
               uword <= uw(op_add, r_a, r_a, PC_START, 32'd1);
            8'h05:
               uword <= uw(op_add, r_b, r_b, PC_START, 32'd1);
            8'h06:
               uword <= uw(op_cmp, r_b, r_i, PC_VERIFY, bus_data_t'(FILL_COUNT));
            8'h07:
               uword <= uw(op_jmp, r_none, r_none, PC_FILL_LOOP, 32'd0);

            // read back and compare
            PC_VERIFY:
               uword <= uw(op_add, r_a, r_none, PC_START, 32'd0);
            8'h09:
               uword <= uw(op_add, r_b, r_none, PC_START, 32'd0);
            PC_VERIFY_LOOP:
               uword <= uw(op_read, r_none, r_none, PC_START, 32'd0); // d = m[a]
            8'h0b:
               uword <= uw(op_cmp, r_d, r_dd, PC_VERIFY_NEXT, 32'd0);
            8'h0c:
               uword <= uw(op_fault, r_none, r_none, PC_START, 32'd0); // mismatch
            PC_VERIFY_NEXT:
               uword <= uw(op_add, r_a, r_a, PC_START, 32'd1);
            8'h0e:
               uword <= uw(op_add, r_b, r_b, PC_START, 32'd1);
            8'h0f:
               uword <= uw(op_cmp, r_b, r_i, HALT_PC, bus_data_t'(FILL_COUNT));
            8'h10:
               uword <= uw(op_jmp, r_none, r_none, PC_VERIFY_LOOP, 32'd0);

            HALT_PC:
               uword <= uw(op_jmp, r_none, r_none, HALT_PC, 32'd0);  // park here

            default:
               uword <= uw(op_jmp, r_none, r_none, PC_START, 32'd0);
         endcase
      end
   end

endmodule

// File: hdl/cpu_test_cpu.sv
/*
 * microsequencer for the memory test
 * pc, four working registers, compare and branch, one request per read or write
 */
`timescale 1ns/100ps

module cpu_test_cpu
   import cpu_test_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   start,
   output upc_t   uaddr,
   input  uword_t uword,
   output upc_t   pc,
   output logic   fault,
   cpu_test_req_if.cpu bus
);

   bus_addr_t a;
   bus_data_t b;
   bus_data_t c;
   bus_data_t d;

   bus_data_t operands [8];
   bus_data_t src_val;
   bus_data_t dst_val;
   bus_data_t alu_out;

   upc_t npc;
   logic primed;
   logic answered;
   logic is_write;
   logic is_read;
   logic is_mem;
   logic answer;
   logic load_pc;
   logic stall;

   assign is_write = uword.op == op_write;
   assign is_read  = uword.op == op_read;
   assign is_mem   = is_write | is_read;
   assign answer   = (is_write & bus.ack) | (is_read & bus.done);
   assign fault    = uword.op == op_fault;

   // operand table indexed by register select
   always_comb
   begin
      operands       = '{default: '0};
      operands[r_a]  = bus_data_t'(a);
      operands[r_b]  = b;
      operands[r_c]  = c;
      operands[r_d]  = d;
      operands[r_i]  = uword.imm;
      operands[r_dd] = pattern_word(a);
   end

   assign src_val = operands[uword.src];
   assign dst_val = operands[uword.dst];
   assign alu_out = (uword.op == op_sub) ? src_val - uword.imm : src_val + uword.imm;

   assign load_pc = (uword.op == op_tst && (dst_val & src_val) == '0) ||
                    (uword.op == op_cmp && dst_val == src_val) ||
                    (uword.op == op_jmp);

   // first cycle after reset still shows the reset nop
   assign stall = ~primed || ~start || fault ||
                  (is_mem && ~answer && ~answered);

   assign npc   = load_pc ? upc_t'(uword.target) : pc + 1'b1;
   assign uaddr = stall ? pc : npc;   // rom output lines up with pc

   assign bus.req   = is_mem & start & ~answered;
   assign bus.wr    = is_write;
   assign bus.addr  = a;
   assign bus.wdata = d;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc     <= '0;
         primed <= 1'b0;
      end
      else
      begin
         primed <= 1'b1;
         if (~stall)
            pc <= npc;
      end
   end

   // remembers an answer that came while start was low
   always_ff @(posedge clk)
   begin
      if (reset)
         answered <= 1'b0;
      else if (~stall)
         answered <= 1'b0;
      else if (answer)
         answered <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         a <= '0;
         b <= '0;
         c <= '0;
         d <= '0;
      end
      else
      begin
         if ((uword.op == op_add || uword.op == op_sub) && ~stall)
         begin
            case (uword.dst)
               r_a:     a <= alu_out[BUS_ADDR_W-1:0];
               r_b:     b <= alu_out;
               r_c:     c <= alu_out;
               r_d:     d <= alu_out;
               default: ;
            endcase
         end
         if (is_read && bus.done)
            d <= bus.rdata;   // read data lands in d
      end
   end

endmodule

// File: hdl/cpu_test_bus_master.sv
/*
 * bus requester
 * registers each sequencer request onto the external bus until it is answered
 */
`timescale 1ns/100ps

module cpu_test_bus_master
   import cpu_test_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   cpu_test_req_if.master bus,
   output logic      mem_rq,
   output logic      mem_wr,
   output bus_addr_t mem_addr,
   output bus_data_t mem_wdata,
   input  logic      mem_ack,
   input  logic      mem_done,
   input  bus_data_t mem_rdata
);

   logic answer;
   logic launch;

   assign answer = mem_ack | mem_done;

   // no launch while a cycle is open or in its answer cycle
   assign launch = bus.req & ~mem_rq;

   assign bus.ack   = mem_rq & mem_ack;
   assign bus.done  = mem_rq & mem_done;
   assign bus.rdata = mem_rdata;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mem_rq <= 1'b0;
         mem_wr <= 1'b0;
      end
      else if (mem_rq)
      begin
         if (answer)
            mem_rq <= 1'b0;   // falls the cycle after the answer
      end
      else if (launch)
      begin
         mem_rq <= 1'b1;
         mem_wr <= bus.wr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (launch)
      begin
         mem_addr  <= bus.addr;
         mem_wdata <= bus.wdata;
      end
   end

endmodule

// File: hdl/cpu_test_top.sv
/*
 * memory test sequencer top level
 * microcode ROM, sequencer and bus requester on one external bus
 */
`timescale 1ns/100ps

module cpu_test_top
   import cpu_test_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   output upc_t      pc,
   output logic      fault,
   output logic      mem_rq,
   output logic      mem_wr,
   output bus_addr_t mem_addr,
   output bus_data_t mem_wdata,
   input  logic      mem_ack,
   input  logic      mem_done,
   input  bus_data_t mem_rdata
);

   upc_t   uaddr;
   uword_t uword;

   cpu_test_req_if req_i ();

   cpu_test_ucode_rom rom_i (
      .clk   (clk),
      .reset (reset),
      .uaddr (uaddr),
      .uword (uword)
   );

   cpu_test_cpu cpu_i (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .uaddr (uaddr),
      .uword (uword),
      .pc    (pc),
      .fault (fault),
      .bus   (req_i.cpu)
   );

   cpu_test_bus_master master_i (
      .clk       (clk),
      .reset     (reset),
      .bus       (req_i.master),
      .mem_rq    (mem_rq),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_done  (mem_done),
      .mem_rdata (mem_rdata)
   );

endmodule

// File: verification/cpu_test_tb.sv
/*
 * testbench for the memory test sequencer
 * plays a bus target with random wait states, runs a clean pass and a corrupted pass
 */
`timescale 1ns/100ps

module cpu_test_tb
   import cpu_test_pkg::*;
();

   localparam int CLK_PERIOD      = 8;
   localparam int WATCHDOG_CYCLES = 2 * (2 * FILL_COUNT * (10 + 8)) * 2;

   typedef logic [7:0] mem_idx_t;

   logic      clk = 1'b0;
   logic      reset;
   logic      start;
   upc_t      pc;
   logic      fault;
   logic      mem_rq;
   logic      mem_wr;
   bus_addr_t mem_addr;
   bus_data_t mem_wdata;
   logic      mem_ack;
   logic      mem_done;
   bus_data_t mem_rdata;

   bus_data_t mem [mem_idx_t];   // target storage keyed by the low address byte
   int        write_count;
   int        read_count;
   logic      corrupt_on;
   int        corrupt_addr;
   int        corrupt_bit;

   cpu_test_top dut_i (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .pc        (pc),
      .fault     (fault),
      .mem_rq    (mem_rq),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_done  (mem_done),
      .mem_rdata (mem_rdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_on_error(string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp)
      else
         stop_on_error($sformatf("** Error at %0d ns: %s is %h, expected %h",
                                 $time, name, got, exp));
   endtask

   // bytes from high to low are ~n, n, n xor 5a and n + 33
   function automatic bus_data_t expected_word(bus_addr_t addr);
      int n;
      n = int'(addr[7:0]);
      return {8'(255 - n), 8'(n), 8'(n ^ 'h5a), 8'((n + 'h33) % 256)};
   endfunction

   function automatic bus_data_t unwritten_word(mem_idx_t idx);
      return {4{idx}} ^ 32'h3c96_e10f;
   endfunction

   task automatic check_held(logic wr, bus_addr_t addr, bus_data_t wdata);
      check_value("mem_rq", 32'(mem_rq), 32'd1);
      check_value("mem_wr", 32'(mem_wr), 32'(wr));
      check_value("mem_addr", 32'(mem_addr), 32'(addr));
      check_value("mem_wdata", mem_wdata, wdata);
   endtask

   // one bus cycle entered at the negedge where mem_rq is first seen
   task automatic serve_request();
      logic      wr;
      bus_addr_t addr;
      bus_data_t wdata;
      mem_idx_t  idx;
      int        wait_cycles;
      wr          = mem_wr;
      addr        = mem_addr;
      wdata       = mem_wdata;
      idx         = addr[7:0];
      wait_cycles = $urandom_range(7, 0);
      if (wr)
      begin
         assert (read_count == 0)
         else
            stop_on_error("write request seen during the verify phase");
         assert (write_count < FILL_COUNT)
         else
            stop_on_error("more write requests than words in the fill phase");
         check_value("mem_addr", 32'(addr), write_count);
         check_value("mem_wdata", wdata, expected_word(addr));
         mem[idx] = wdata;
         write_count++;
      end
      else
      begin
         assert (write_count == FILL_COUNT)
         else
            stop_on_error("read request before the fill phase was complete");
         assert (read_count < FILL_COUNT)
         else
            stop_on_error("more read requests than words in the verify phase");
         check_value("mem_addr", 32'(addr), read_count);
         if (corrupt_on && read_count == corrupt_addr)
            mem[idx] = mem[idx] ^ (32'd1 << corrupt_bit);   // single bit upset
         read_count++;
      end
      repeat (wait_cycles)
      begin
         @(negedge clk);
         check_held(wr, addr, wdata);
      end
      @(posedge clk);
      #1;
      if (wr)
         mem_ack = 1'b1;
      else
      begin
         mem_done  = 1'b1;
         mem_rdata = mem.exists(idx) ? mem[idx] : unwritten_word(idx);
      end
      @(negedge clk);
      check_held(wr, addr, wdata);
      @(posedge clk);
      #1;
      mem_ack   = 1'b0;
      mem_done  = 1'b0;
      mem_rdata = $urandom;   // stale data must not be used
      @(negedge clk);
      check_value("mem_rq", 32'(mem_rq), 32'd0);
   endtask

   // bus target
   initial
   begin
      mem_ack     = 1'b0;
      mem_done    = 1'b0;
      mem_rdata   = '0;
      write_count = 0;
      read_count  = 0;
      forever
      begin
         @(negedge clk);
         if (reset !== 1'b0)
         begin
            write_count = 0;
            read_count  = 0;
            mem.delete();
         end
         else if (mem_rq === 1'b1)
            serve_request();
      end
   end

   task automatic apply_reset();
      @(posedge clk);
      #1;
      reset = 1'b1;
      start = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
   endtask

   task automatic idle_then_start();
      int idle;
      idle = $urandom_range(20, 5);
      repeat (idle)
      begin
         @(negedge clk);
         check_value("mem_rq", 32'(mem_rq), 32'd0);
         check_value("fault", 32'(fault), 32'd0);
         check_value("pc", 32'(pc), 32'd0);
      end
      @(posedge clk);
      #1;
      start = 1'b1;
   endtask

   task automatic run_to_halt();
      while (pc !== HALT_PC)
      begin
         @(negedge clk);
         check_value("fault", 32'(fault), 32'd0);
      end
      check_value("write count", write_count, FILL_COUNT);
      check_value("read count", read_count, FILL_COUNT);
      repeat (50)
      begin
         @(negedge clk);
         check_value("pc", 32'(pc), 32'(HALT_PC));
         check_value("fault", 32'(fault), 32'd0);
         check_value("mem_rq", 32'(mem_rq), 32'd0);
      end
   endtask

   task automatic run_to_fault();
      while (fault !== 1'b1 && pc !== HALT_PC)
         @(negedge clk);
      assert (fault === 1'b1)
      else
         stop_on_error("program reached the halt loop although a stored word was corrupted");
      check_value("mem_addr", 32'(mem_addr), 32'(corrupt_addr));
      check_value("read count", read_count, corrupt_addr + 1);
      repeat (50)
      begin
         @(negedge clk);
         check_value("fault", 32'(fault), 32'd1);
         check_value("mem_rq", 32'(mem_rq), 32'd0);
      end
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stop_on_error($sformatf("timeout: test did not end within %0d cycles",
                              WATCHDOG_CYCLES));
   end

   initial
   begin
      reset        = 1'b1;
      start        = 1'b0;
      corrupt_on   = 1'b0;
      corrupt_addr = 0;
      corrupt_bit  = 0;
      void'($urandom(87));
      apply_reset();
      idle_then_start();
      run_to_halt();
      corrupt_addr = $urandom_range(FILL_COUNT - 1, 0);
      corrupt_bit  = $urandom_range(31, 0);
      corrupt_on   = 1'b1;
      apply_reset();
      idle_then_start();
      run_to_fault();
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: sources.f
hdl/cpu_test_pkg.sv
hdl/cpu_test_req_if.sv
hdl/cpu_test_ucode_rom.sv
hdl/cpu_test_cpu.sv
hdl/cpu_test_bus_master.sv
hdl/cpu_test_top.sv
verification/cpu_test_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the memory test sequencer testbench
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_test_tb \
   -f sources.f -o cpu_test_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpu_test_sim > sim.log 2>&1 || true
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation failed"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
